/* src.f */
hw/mips_pkg.sv
hw/decode_if.sv
hw/instr_rom.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/mips_core.sv
hw/mips_sys.sv
bench/tb_mips_sys.sv

/* Makefile */
TOP := tb_mips_sys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f src.f \
		--top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_mips_sys.sv */
`timescale 1ns/1ns

module tb_mips_sys;
    import mips_pkg::*;

    localparam int MEM_WORDS   = 128;
    localparam int PROG_CYCLES = 31;
    localparam int HALT_LIMIT  = 200;
    localparam int START_LIMIT = 4;

    logic       clk;
    logic       arst_n;
    addr_t      data_address;
    logic       data_read;
    logic       data_write;
    word_t      data_writedata;
    logic [3:0] data_byteenable;
    word_t      data_readdata;
    logic       active;
    word_t      register_v0;

    // data memory model where words 0..63 feed the loads and 64 and up take the stores
    word_t mem      [0:MEM_WORDS-1];
    word_t mem_init [0:MEM_WORDS-1];

    // reference model register state
    word_t exp_reg [0:31];

    mips_sys u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .data_address    (data_address),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_writedata  (data_writedata),
        .data_byteenable (data_byteenable),
        .data_readdata   (data_readdata),
        .active          (active),
        .register_v0     (register_v0)
    );

    // read data valid in the same cycle as the strobe
    assign data_readdata = mem[data_address[8:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // fresh random memory and registers back to their reset value
    task automatic fill_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a]      = $urandom();
            mem_init[a] = mem[a];
        end
        for (int r = 0; r < 32; r++) begin
            exp_reg[r] = '0;
        end
    endtask

    task automatic store_word(input addr_t addr, input word_t data, input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                mem[addr[8:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // bus must stay quiet while reset is held for 8 edges
    task automatic apply_reset();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        fill_memory();
        repeat (8) begin
            @(negedge clk);
            check_word("active", 32'(active), 32'd0);
            check_word("data_read", 32'(data_read), 32'd0);
            check_word("data_write", 32'(data_write), 32'd0);
            check_word("data_byteenable", 32'(data_byteenable), 32'd0);
            @(posedge clk);
        end
        #2;
        arst_n = 1'b1;
    endtask

    // expected bus activity of program cycle k
    task automatic check_cycle(input int k);
        logic       exp_read;
        logic       exp_write;
        logic [3:0] exp_be;

        exp_read  = (k <= 14);
        exp_write = (k >= 15) && (k <= 28);
        exp_be    = exp_read ? 4'b1111 : (exp_write ? 4'b0011 : 4'b0000);
        check_word("data_read", 32'(data_read), 32'(exp_read));
        check_word("data_write", 32'(data_write), 32'(exp_write));
        check_word("data_byteenable", 32'(data_byteenable), 32'(exp_be));
        check_word("register_v0", register_v0, exp_reg[2]);
        if (exp_read) begin
            check_word("data_address", data_address, 32'(4 * k));
        end
        if (exp_write) begin
            // store j writes r(j+2) which holds load word j
            check_word("data_address", data_address, 32'(32'h100 + 4 * (k - 15)));
            check_word("data_writedata[15:0]", 32'(data_writedata[15:0]),
                       32'(exp_reg[k - 13][15:0]));
        end
    endtask

    // steps the program cycle by cycle until halt or max_cycles
    task automatic run_program(input int max_cycles, output int cycles);
        int         waited;
        int         k;
        logic       wr_pend;
        addr_t      wr_addr;
        word_t      wr_data;
        logic [3:0] wr_be;

        waited = 0;
        k      = 0;
        @(negedge clk);
        while (!active && waited < START_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (active && waited == 0)
        else report_failure("active did not rise in the first cycle after reset");
        while (active && k < max_cycles) begin
            check_cycle(k);
            wr_pend = data_write;
            wr_addr = data_address;
            wr_data = data_writedata;
            wr_be   = data_byteenable;
            // register effects land at the edge ending cycle k
            if (k <= 14) begin
                exp_reg[k + 2] = mem[k];
            end
            if (k == 30) begin
                exp_reg[2] = '0;
            end
            @(posedge clk);
            #2;
            if (wr_pend) begin
                store_word(wr_addr, wr_data, wr_be);
            end
            @(negedge clk);
            k++;
        end
        cycles = k;
    endtask

    // halted core keeps the bus idle and v0 cleared
    task automatic check_idle(input int n);
        repeat (n) begin
            check_word("active", 32'(active), 32'd0);
            check_word("data_read", 32'(data_read), 32'd0);
            check_word("data_write", 32'(data_write), 32'd0);
            check_word("data_byteenable", 32'(data_byteenable), 32'd0);
            check_word("register_v0", register_v0, 32'd0);
            @(negedge clk);
        end
    endtask

    // low lanes hold the loaded halfwords and high lanes stay untouched
    task automatic check_memory();
        for (int j = 0; j < 14; j++) begin
            check_word($sformatf("mem[0x%h][15:0]", 32'h100 + 4 * j),
                       32'(mem[64 + j][15:0]), 32'(mem_init[j][15:0]));
            check_word($sformatf("mem[0x%h][31:16]", 32'h100 + 4 * j),
                       32'(mem[64 + j][31:16]), 32'(mem_init[64 + j][31:16]));
        end
        check_word("mem[0x138]", mem[78], mem_init[78]);
    endtask

    task automatic full_run();
        int n;

        run_program(HALT_LIMIT, n);
        assert (n < HALT_LIMIT) else report_failure("core never halted");
        check_word("active cycle count", 32'(n), 32'(PROG_CYCLES));
        check_idle(10);
        check_memory();
    endtask

    initial begin
        int n;

        arst_n = 1'b0;
        void'($urandom(32'ha91c_b992));
        // read data is defined from time zero
        fill_memory();
        apply_reset();
        full_run();
        // second reset lands in the middle of the load sequence
        apply_reset();
        run_program(12, n);
        check_word("cycles before second reset", 32'(n), 32'd12);
        apply_reset();
        full_run();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* hw/mips_sys.sv */
`timescale 1ns/1ns

module mips_sys (
    input  logic            clk,
    input  logic            arst_n,
    output mips_pkg::addr_t data_address,
    output logic            data_read,
    output logic            data_write,
    output mips_pkg::word_t data_writedata,
    output logic [3:0]      data_byteenable,
    input  mips_pkg::word_t data_readdata,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    // fetch path between core and ROM
    addr_t instr_address;
    word_t instr_readdata;

    mips_core u_core (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr_address   (instr_address),
        .instr_readdata  (instr_readdata),
        .data_address    (data_address),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_writedata  (data_writedata),
        .data_byteenable (data_byteenable),
        .data_readdata   (data_readdata),
        .active          (active),
        .register_v0     (register_v0)
    );

    instr_rom u_rom (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ns

module mips_core (
    input  logic            clk,
    input  logic            arst_n,
    output mips_pkg::addr_t instr_address,
    input  mips_pkg::word_t instr_readdata,
    output mips_pkg::addr_t data_address,
    output logic            data_read,
    output logic            data_write,
    output mips_pkg::word_t data_writedata,
    output logic [3:0]      data_byteenable,
    input  mips_pkg::word_t data_readdata,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    decode_if dec_bus ();

    // program counter and delay-slot target
    addr_t pc_q;
    logic  pend_q;
    addr_t pend_tgt_q;

    logic  halted;
    logic  run;

    word_t rs_data;
    word_t rt_data;
    addr_t ea;
    logic  rf_we;
    word_t rf_wr_data;

    instr_decode u_dec (
        .instr (instr_readdata),
        .dec   (dec_bus)
    );

    reg_file u_rf (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (dec_bus.rs),
        .rt_idx  (dec_bus.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (rf_we),
        .wr_idx  (dec_bus.dest),
        .wr_data (rf_wr_data),
        .v0      (register_v0)
    );

    // pc of zero is the halt state, held until reset
    assign halted = (pc_q == '0);

    // core executes only out of reset and before halt
    assign run    = arst_n && !halted;
    assign active = run;

    assign instr_address = pc_q;

    // one adder covers the memory address and the addiu sum
    assign ea = rs_data + dec_bus.imm_sext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q   <= RESET_VECTOR;
            pend_q <= 1'b0;
        end else if (!halted) begin
            // a pending jr target is taken after its delay slot
            if (pend_q) begin
                pc_q <= pend_tgt_q;
            end else begin
                pc_q <= pc_q + 32'd4;
            end
            pend_q <= dec_bus.is_jr;
        end
    end

    // target captured while jr executes
    always_ff @(posedge clk) begin
        if (dec_bus.is_jr) begin
            pend_tgt_q <= rs_data;
        end
    end

    // data bus, word aligned
    assign data_address = {ea[31:2], 2'b00};
    assign data_read    = run && dec_bus.is_load;
    assign data_write   = run && dec_bus.is_store_half;

    // halfword goes to the lane picked by address bit 1
    assign data_writedata = ea[1] ? {rt_data[15:0], 16'h0000} : {16'h0000, rt_data[15:0]};

    always_comb begin
        data_byteenable = 4'b0000;
        if (data_read) begin
            data_byteenable = 4'b1111;
        end else if (data_write) begin
            data_byteenable = ea[1] ? 4'b1100 : 4'b0011;
        end
    end

    // write-back, lw takes the bus word and addiu the sum
    assign rf_we      = run && dec_bus.reg_we;
    assign rf_wr_data = dec_bus.is_load ? data_readdata : ea;

endmodule

/* hw/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode (
    input mips_pkg::word_t instr,
    decode_if.dec          dec
);
    import mips_pkg::*;

    opcode_t     opcode;
    funct_t      funct;
    logic [15:0] imm;

    // fixed field positions shared by I-type and R-type
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    assign dec.rs = instr[25:21];
    assign dec.rt = instr[20:16];

    // sign extension for addiu and the memory offset
    assign dec.imm_sext = {{16{imm[15]}}, imm};

    // instruction class
    assign dec.is_load       = (opcode == OP_LW);
    assign dec.is_store_half = (opcode == OP_SH);
    assign dec.is_addiu      = (opcode == OP_ADDIU);
    assign dec.is_jr         = (opcode == OP_SPECIAL) && (funct == FN_JR);

    // only lw and addiu write back, both into rt
    always_comb begin
        dec.reg_we = 1'b0;
        dec.dest   = 5'd0;
        if (dec.is_load || dec.is_addiu) begin
            dec.reg_we = 1'b1;
            dec.dest   = instr[20:16];
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  logic               we,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (we && (wr_idx != 5'd0)) begin
            // r0 is never written so it reads as zero
            regs[wr_idx] <= wr_data;
        end
    end

    // read ports see the value before this cycle's write
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // v0 lives in r2
    assign v0 = regs[2];

endmodule

/* hw/instr_rom.sv */
`timescale 1ns/1ns

module instr_rom (
    input  mips_pkg::addr_t instr_address,
    output mips_pkg::word_t instr_readdata
);
    import mips_pkg::*;

    word_t rom [0:ROM_WORDS-1];

    // byte offset from the start of the program
    addr_t offset;

    // instruction fields used while assembling the program
    opcode_t     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    funct_t      funct;

    // program build at time zero
    initial begin
        int w;
        int i;

        for (w = 0; w < ROM_WORDS; w++) begin
            rom[w] = '0;
        end
        w = 0;

        // lw ri, 4*(i-2)(r0) for r2 to r16
        for (i = 2; i <= 16; i++) begin
            opcode = OP_LW;
            rs     = 5'd0;
            rt     = reg_idx_t'(i);
            imm    = 16'((i - 2) * 4);
            rom[w] = {opcode, rs, rt, imm};
            w++;
        end

        // sh ri, 0x100 + 4*(i-2)(r0) for r2 to r15
        for (i = 2; i <= 15; i++) begin
            opcode = OP_SH;
            rs     = 5'd0;
            rt     = reg_idx_t'(i);
            imm    = 16'(16'h100 + (i - 2) * 4);
            rom[w] = {opcode, rs, rt, imm};
            w++;
        end

        // jr r0, the core halts once the target is taken
        opcode = OP_SPECIAL;
        rs     = 5'd0;
        rt     = 5'd0;
        rd     = 5'd0;
        shamt  = 5'd0;
        funct  = FN_JR;
        rom[w] = {opcode, rs, rt, rd, shamt, funct};
        w++;

        // delay slot, addiu r2, r0, 0 clears v0
        opcode = OP_ADDIU;
        rs     = 5'd0;
        rt     = 5'd2;
        imm    = 16'h0;
        rom[w] = {opcode, rs, rt, imm};
    end

    assign offset = instr_address - RESET_VECTOR;

    // word select drops the byte bits
    assign instr_readdata = rom[offset[ROM_AW+1:2]];

endmodule

/* hw/decode_if.sv */
`timescale 1ns/1ns

interface decode_if;
    import mips_pkg::*;

    // source register indices
    reg_idx_t rs;
    reg_idx_t rt;

    // immediate, sign extended to a full word
    word_t    imm_sext;

    // one-hot instruction class
    logic     is_load;
    logic     is_store_half;
    logic     is_addiu;
    logic     is_jr;

    // register write request and its target
    logic     reg_we;
    reg_idx_t dest;

    modport dec (
        output rs, rt, imm_sext, is_load, is_store_half, is_addiu, is_jr, reg_we, dest
    );

    modport core (
        input rs, rt, imm_sext, is_load, is_store_half, is_addiu, is_jr, reg_we, dest
    );

endinterface

/* hw/mips_pkg.sv */
package mips_pkg;

    // data or instruction word
    typedef logic [31:0] word_t;

    // byte address on either bus
    typedef logic [31:0] addr_t;

    // register index, 32 registers
    typedef logic [4:0] reg_idx_t;

    // primary opcode field
    typedef logic [5:0] opcode_t;

    // R-type function field
    typedef logic [5:0] funct_t;

    // primary opcodes of the supported subset
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_LW      = 6'b100011;

    // halfword store, encoded as the ROM program uses it
    localparam opcode_t OP_SH      = 6'b101001;

    // funct code of jr under OP_SPECIAL
    localparam funct_t FN_JR = 6'b001000;

    // pc after reset and base address of the ROM
    localparam addr_t RESET_VECTOR = 32'hBFC0_0000;

    // instruction ROM depth in words
    localparam int ROM_WORDS = 4096;

    // word index width into the ROM
    localparam int ROM_AW = $clog2(ROM_WORDS);

endpackage
